//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= compile.f
TB_TOP    ?= tb_soc_bus
RTL_TOP   ?= soc_bus_top
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timescale 1ns/1ps
PASS_TEXT ?= ALL TESTS PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FILELIST) \
		--top-module $(TB_TOP) --Mdir $(BUILD_DIR)

sim: build
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- compile.f
src/bus_pkg.sv
src/bus_delay_gate.sv
src/sram_slave.sv
src/uart_slave.sv
src/clint_slave.sv
src/bus_xbar.sv
src/soc_bus_top.sv
dv/tb_soc_bus.sv

//--- dv/bus_stim.txt
# op addr wdata strb exp_data exp_resp console_byte mode name (numbers in hex, console 0/1)
# op r read, w write; mode e exact, g above previous timer read, z zero
w 80000000 11223344 f 00000000 0 0 e sram_wr_w0
w 80000004 deadbeef f 00000000 0 0 e sram_wr_w1
w 800003fc 0badf00d f 00000000 0 0 e sram_wr_last
r 80000000 00000000 0 11223344 0 0 e sram_rd_w0
r 80000004 00000000 0 deadbeef 0 0 e sram_rd_w1
r 800003fc 00000000 0 0badf00d 0 0 e sram_rd_last
w 80000004 a5c3e17f 5 00000000 0 0 e strb_wr_w1
r 80000004 00000000 0 dec3be7f 0 0 e strb_rd_w1
w a00003f8 00000048 f 00000000 0 1 e uart_wr_h
w a00003f8 ffffff69 0 00000000 0 1 e uart_wr_nostrb
r a00003f8 00000000 0 00000000 0 0 z uart_rd
r a0000048 00000000 0 00000000 0 0 g rtc_lo_first
r a0000048 00000000 0 00000000 0 0 g rtc_lo_second
r a000004c 00000000 0 00000000 0 0 z rtc_hi
w a0000048 00000000 f 00000000 0 0 e rtc_wr
r a0000048 00000000 0 00000000 0 0 g rtc_lo_after_wr
r 90000000 00000000 0 00000000 3 0 z decerr_rd
w 90000000 12345678 f 00000000 3 0 e decerr_wr
r 80000400 00000000 0 00000000 3 0 z past_sram_rd
w 80000400 55aa55aa f 00000000 3 0 e past_sram_wr
r 80000000 00000000 0 11223344 0 0 e sram_rd_w0_again

//--- dv/tb_soc_bus.sv
`timescale 1ns/1ps

module tb_soc_bus;
  import bus_pkg::*;

  localparam string STIM_FILE = "dv/bus_stim.txt";

  logic clk;
  logic rst;
  logic [ADDR_W-1:0] araddr;
  logic arvalid;
  logic [DATA_W-1:0] rdata;
  resp_t rresp;
  logic rvalid;
  logic rready;
  logic [ADDR_W-1:0] awaddr;
  logic awvalid;
  logic [DATA_W-1:0] wdata;
  logic [STRB_W-1:0] wstrb;
  logic wvalid;
  resp_t bresp;
  logic bvalid;
  logic bready;
  logic [7:0] tx_byte;
  logic tx_valid;

  // One entry per stimulus line
  string             op_q[$];
  logic [ADDR_W-1:0] addr_q[$];
  logic [DATA_W-1:0] wdata_q[$];
  logic [STRB_W-1:0] strb_q[$];
  logic [DATA_W-1:0] exp_data_q[$];
  resp_t             exp_resp_q[$];
  bit                exp_tx_q[$];
  string             mode_q[$];
  string             name_q[$];

  logic [31:0] rng = 32'hc9d8;
  logic [DATA_W-1:0] prev_lo = '0;  // Last timer value seen by an increasing check
  int unsigned cycle_cnt = 0;
  int unsigned cycle_limit = 100;
  int r_pulses = 0;
  int b_pulses = 0;
  int tx_pulses = 0;
  int data_errs = 0;
  int resp_errs = 0;
  int tx_errs = 0;
  int proto_errs = 0;

  soc_bus_top #(
    .DELAY_EN  (1'b1),
    .SRAM_WORDS(256)
  ) i_soc_bus_top (
    .clk, .rst,
    .araddr_i(araddr), .arvalid_i(arvalid), .rdata_o(rdata), .rresp_o(rresp),
    .rvalid_o(rvalid), .rready_i(rready),
    .awaddr_i(awaddr), .awvalid_i(awvalid), .wdata_i(wdata), .wstrb_i(wstrb),
    .wvalid_i(wvalid), .bresp_o(bresp), .bvalid_o(bvalid), .bready_i(bready),
    .tx_byte_o(tx_byte), .tx_valid_o(tx_valid)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout: a response never arrived within %0d cycles", cycle_limit);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // Right-shifting Galois form, x^32 + x^31 + x^29 + x + 1
  function automatic logic [31:0] galois_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hd000_0001) : (s >> 1);
  endfunction

  function automatic int unsigned take_bits(input int unsigned n);
    int unsigned v;
    v = 0;
    for (int unsigned k = 0; k < n; k++) begin
      v = (v << 1) | 32'(rng[0]);
      rng = galois_step(rng);
    end
    return v;
  endfunction

  // Every wait passes through here so each response pulse is counted once
  task automatic tick();
    @(negedge clk);
    if (rvalid) r_pulses++;
    if (bvalid) b_pulses++;
    if (tx_valid) tx_pulses++;
  endtask

  task automatic check_data(input string name, input logic [DATA_W-1:0] exp_v,
                            input logic [DATA_W-1:0] act_v);
    if (act_v !== exp_v) begin
      $display("mismatch %s data expected %h actual %h", name, exp_v, act_v);
      data_errs++;
    end
  endtask

  task automatic check_later(input string name, input logic [DATA_W-1:0] floor_v,
                             input logic [DATA_W-1:0] act_v);
    if (act_v <= floor_v) begin
      $display("mismatch %s data expected above %h actual %h", name, floor_v, act_v);
      data_errs++;
    end
  endtask

  task automatic check_resp(input string name, input resp_t exp_v, input resp_t act_v);
    if (act_v !== exp_v) begin
      $display("mismatch %s response expected %0d actual %0d", name, exp_v, act_v);
      resp_errs++;
    end
  endtask

  task automatic check_tx(input string name, input logic [7:0] exp_v, input logic [7:0] act_v);
    if (act_v !== exp_v) begin
      $display("mismatch %s console byte expected %h actual %h", name, exp_v, act_v);
      tx_errs++;
    end
  endtask

  task automatic load_stimulus(output bit ok);
    int fd;
    int n;
    string line;
    string f_op;
    string f_mode;
    string f_name;
    logic [31:0] f_addr, f_wdata, f_strb, f_data, f_resp;
    int f_tx;
    ok = 1'b0;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("cannot open stimulus file %s", STIM_FILE);
      return;
    end
    while ($fgets(line, fd) > 0) begin
      if (line.len() < 2 || line.getc(0) == "#") continue;
      n = $sscanf(line, "%s %h %h %h %h %h %d %s %s", f_op, f_addr, f_wdata, f_strb,
                  f_data, f_resp, f_tx, f_mode, f_name);
      if (n != 9) begin
        $display("stimulus line could not be parsed: %s", line);
        proto_errs++;
        continue;
      end
      op_q.push_back(f_op);
      addr_q.push_back(f_addr);
      wdata_q.push_back(f_wdata);
      strb_q.push_back(f_strb[STRB_W-1:0]);
      exp_data_q.push_back(f_data);
      exp_resp_q.push_back(f_resp[1:0]);
      exp_tx_q.push_back(f_tx != 0);
      mode_q.push_back(f_mode);
      name_q.push_back(f_name);
    end
    $fclose(fd);
    if (op_q.size() == 0) $display("stimulus file holds no transactions");
    ok = (op_q.size() > 0);
  endtask

  task automatic run_txn(input int idx);
    int unsigned idle;
    int unsigned stall;
    int unsigned waited;
    int r0;
    int b0;
    int t0;
    bit is_rd;
    bit rdy_prev;
    bit got;
    bit tx_at_pulse;
    logic [DATA_W-1:0] data_seen;
    logic [7:0] byte_seen;
    resp_t resp_seen;
    string name;
    name = name_q[idx];
    is_rd = (op_q[idx] == "r");
    r0 = r_pulses;
    b0 = b_pulses;
    t0 = tx_pulses;
    idle = take_bits(2);
    repeat (idle) tick();
    stall = take_bits(2);  // Cycles that ready stays low after valid rises
    if (is_rd) begin
      araddr = addr_q[idx];
      arvalid = 1'b1;
      rready = (stall == 0);
    end else begin
      awaddr = addr_q[idx];
      wdata = wdata_q[idx];
      wstrb = strb_q[idx];
      awvalid = 1'b1;
      wvalid = 1'b1;
      bready = (stall == 0);
    end
    got = 1'b0;
    waited = 0;
    while (!got) begin
      rdy_prev = is_rd ? rready : bready;
      tick();
      waited++;
      if (waited == stall) begin
        rready = is_rd;
        bready = !is_rd;
      end
      if (is_rd ? rvalid : bvalid) begin
        got = 1'b1;
        data_seen = rdata;
        resp_seen = is_rd ? rresp : bresp;
        tx_at_pulse = tx_valid;
        byte_seen = tx_byte;
        // Decode errors answer regardless of ready
        if (!rdy_prev && exp_resp_q[idx] != RESP_DECERR) begin
          $display("%s: response pulse appeared while ready was held low", name);
          proto_errs++;
        end
      end
    end
    arvalid = 1'b0;
    awvalid = 1'b0;
    wvalid = 1'b0;
    rready = 1'b0;
    bready = 1'b0;
    tick();
    if (r_pulses - r0 != (is_rd ? 1 : 0) || b_pulses - b0 != (is_rd ? 0 : 1)) begin
      $display("%s: expected a single response pulse but saw %0d read and %0d write pulses",
               name, r_pulses - r0, b_pulses - b0);
      proto_errs++;
    end
    if (tx_pulses - t0 != int'(exp_tx_q[idx])) begin
      $display("%s: expected %0d console strobes but saw %0d", name,
               int'(exp_tx_q[idx]), tx_pulses - t0);
      proto_errs++;
    end
    if (is_rd) begin
      if (mode_q[idx] == "g") begin
        check_later(name, prev_lo, data_seen);
        prev_lo = data_seen;
      end else if (mode_q[idx] == "z") begin
        check_data(name, '0, data_seen);
      end else begin
        check_data(name, exp_data_q[idx], data_seen);
      end
    end
    check_resp(name, exp_resp_q[idx], resp_seen);
    if (exp_tx_q[idx]) begin
      if (!tx_at_pulse) begin
        $display("%s: console strobe was not in the cycle of the write response", name);
        proto_errs++;
      end
      check_tx(name, wdata_q[idx][7:0], byte_seen);
    end
  endtask

  initial begin
    bit loaded;
    int total;
    clk = 1'b0;
    rst = 1'b1;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    load_stimulus(loaded);
    if (!loaded) begin
      $display("SOME TESTS FAILED");
      $finish;
    end else begin
      cycle_limit = op_q.size() * 30 + 100;
      repeat (4) @(negedge clk);
      rst = 1'b0;
      foreach (op_q[i]) run_txn(i);
      total = data_errs + resp_errs + tx_errs + proto_errs;
      $display("errors: data %0d, response %0d, console %0d, protocol %0d",
               data_errs, resp_errs, tx_errs, proto_errs);
      if (total == 0) begin
        $display("ALL TESTS PASSED");
      end else begin
        $display("SOME TESTS FAILED");
      end
      $finish;
    end
  end

endmodule

//--- src/bus_delay_gate.sv
`timescale 1ns/1ps

module bus_delay_gate #(
  parameter bit DELAY_EN = 1'b1,
  parameter logic [bus_pkg::LFSR_W-1:0] LFSR_SEED = 20'h00065
) (
  input  logic clk,
  input  logic rst,
  output logic ready_o
);
  import bus_pkg::*;

  logic [LFSR_W-1:0] lfsr;

  // Fibonacci form, feedback from bits 19 and 18
  always_ff @(posedge clk) begin
    if (rst) begin
      lfsr <= LFSR_SEED;
    end else begin
      lfsr <= {lfsr[LFSR_W-2:0], lfsr[LFSR_W-1] ^ lfsr[LFSR_W-2]};
    end
  end

  assign ready_o = DELAY_EN ? lfsr[LFSR_W-1] : 1'b1;

endmodule

//--- src/bus_pkg.sv
package bus_pkg;

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned STRB_W = DATA_W / 8;  // One strobe bit per byte lane

  // Width of the response delay generator in each slave
  localparam int unsigned LFSR_W = 20;

  localparam logic [ADDR_W-1:0] SRAM_BASE    = 32'h8000_0000;
  localparam logic [ADDR_W-1:0] UART_TX_ADDR = 32'ha000_03f8;
  localparam logic [ADDR_W-1:0] RTC_ADDR_LO  = 32'ha000_0048;
  localparam logic [ADDR_W-1:0] RTC_ADDR_HI  = 32'ha000_004c;

  typedef logic [1:0] resp_t;

  localparam resp_t RESP_OKAY   = 2'd0;  // Zero so idle slaves merge cleanly
  localparam resp_t RESP_DECERR = 2'd3;

endpackage

//--- src/bus_xbar.sv
`timescale 1ns/1ps

module bus_xbar #(
  parameter int unsigned SRAM_WORDS = 256
) (
  input  logic clk,
  input  logic rst,
  input  logic [bus_pkg::ADDR_W-1:0] araddr_i,
  input  logic arvalid_i,
  output logic [bus_pkg::DATA_W-1:0] rdata_o,
  output bus_pkg::resp_t rresp_o,
  output logic rvalid_o,
  input  logic rready_i,
  input  logic [bus_pkg::ADDR_W-1:0] awaddr_i,
  input  logic awvalid_i,
  input  logic [bus_pkg::DATA_W-1:0] wdata_i,
  input  logic [bus_pkg::STRB_W-1:0] wstrb_i,
  input  logic wvalid_i,
  output bus_pkg::resp_t bresp_o,
  output logic bvalid_o,
  input  logic bready_i,
  output logic [bus_pkg::ADDR_W-1:0] sram_araddr_o, sram_awaddr_o,
  output logic sram_arvalid_o, sram_rready_o, sram_awvalid_o, sram_wvalid_o, sram_bready_o,
  output logic [bus_pkg::DATA_W-1:0] sram_wdata_o,
  output logic [bus_pkg::STRB_W-1:0] sram_wstrb_o,
  input  logic [bus_pkg::DATA_W-1:0] sram_rdata_i,
  input  bus_pkg::resp_t sram_rresp_i, sram_bresp_i,
  input  logic sram_rvalid_i, sram_bvalid_i,
  output logic [bus_pkg::ADDR_W-1:0] uart_araddr_o, uart_awaddr_o,
  output logic uart_arvalid_o, uart_rready_o, uart_awvalid_o, uart_wvalid_o, uart_bready_o,
  output logic [bus_pkg::DATA_W-1:0] uart_wdata_o,
  output logic [bus_pkg::STRB_W-1:0] uart_wstrb_o,
  input  logic [bus_pkg::DATA_W-1:0] uart_rdata_i,
  input  bus_pkg::resp_t uart_rresp_i, uart_bresp_i,
  input  logic uart_rvalid_i, uart_bvalid_i,
  output logic [bus_pkg::ADDR_W-1:0] clint_araddr_o, clint_awaddr_o,
  output logic clint_arvalid_o, clint_rready_o, clint_awvalid_o, clint_wvalid_o, clint_bready_o,
  output logic [bus_pkg::DATA_W-1:0] clint_wdata_o,
  output logic [bus_pkg::STRB_W-1:0] clint_wstrb_o,
  input  logic [bus_pkg::DATA_W-1:0] clint_rdata_i,
  input  bus_pkg::resp_t clint_rresp_i, clint_bresp_i,
  input  logic clint_rvalid_i, clint_bvalid_i
);
  import bus_pkg::*;

  localparam logic [ADDR_W-1:0] SRAM_END = SRAM_BASE + ADDR_W'(4 * SRAM_WORDS);

  logic [2:0] rd_sel;
  logic [2:0] wr_sel;
  logic rd_err;
  logic wr_err;
  logic err_rvalid;
  logic err_bvalid;
  logic rd_pend;
  logic wr_pend;

  // One-hot select, bit 0 SRAM, bit 1 console, bit 2 timer
  function automatic logic [2:0] decode(input logic [ADDR_W-1:0] addr);
    logic [2:0] sel;
    sel = 3'b000;
    sel[0] = (addr >= SRAM_BASE) && (addr < SRAM_END);
    sel[1] = addr[ADDR_W-1:2] == UART_TX_ADDR[ADDR_W-1:2];
    // The timer slot spans four words, only two of them are registers
    sel[2] = addr[ADDR_W-1:4] == RTC_ADDR_LO[ADDR_W-1:4];
    return sel;
  endfunction

  assign rd_sel = decode(araddr_i);
  assign wr_sel = decode(awaddr_i);
  assign rd_err = arvalid_i & ~|rd_sel;
  assign wr_err = awvalid_i & wvalid_i & ~|wr_sel;

  assign sram_araddr_o   = araddr_i;
  assign sram_arvalid_o  = arvalid_i & rd_sel[0];
  assign sram_rready_o   = rready_i;
  assign sram_awaddr_o   = awaddr_i;
  assign sram_awvalid_o  = awvalid_i & wr_sel[0];
  assign sram_wdata_o    = wdata_i;
  assign sram_wstrb_o    = wstrb_i;
  assign sram_wvalid_o   = wvalid_i & wr_sel[0];
  assign sram_bready_o   = bready_i;

  assign uart_araddr_o   = araddr_i;
  assign uart_arvalid_o  = arvalid_i & rd_sel[1];
  assign uart_rready_o   = rready_i;
  assign uart_awaddr_o   = awaddr_i;
  assign uart_awvalid_o  = awvalid_i & wr_sel[1];
  assign uart_wdata_o    = wdata_i;
  assign uart_wstrb_o    = wstrb_i;
  assign uart_wvalid_o   = wvalid_i & wr_sel[1];
  assign uart_bready_o   = bready_i;

  assign clint_araddr_o  = araddr_i;
  assign clint_arvalid_o = arvalid_i & rd_sel[2];
  assign clint_rready_o  = rready_i;
  assign clint_awaddr_o  = awaddr_i;
  assign clint_awvalid_o = awvalid_i & wr_sel[2];
  assign clint_wdata_o   = wdata_i;
  assign clint_wstrb_o   = wstrb_i;
  assign clint_wvalid_o  = wvalid_i & wr_sel[2];
  assign clint_bready_o  = bready_i;

  // Pending stays set until the master drops valid, so one pulse per request
  always_ff @(posedge clk) begin
    if (rst) begin
      err_rvalid <= 1'b0;
      err_bvalid <= 1'b0;
      rd_pend    <= 1'b0;
      wr_pend    <= 1'b0;
    end else begin
      err_rvalid <= rd_err & ~rd_pend;
      err_bvalid <= wr_err & ~wr_pend;
      rd_pend    <= arvalid_i & (rd_pend | rd_err);
      wr_pend    <= awvalid_i & (wr_pend | wr_err);
    end
  end

  // Idle slaves hold zero on every response signal
  assign rdata_o  = sram_rdata_i | uart_rdata_i | clint_rdata_i;
  assign rresp_o  = sram_rresp_i | uart_rresp_i | clint_rresp_i |
                    (err_rvalid ? RESP_DECERR : RESP_OKAY);
  assign rvalid_o = sram_rvalid_i | uart_rvalid_i | clint_rvalid_i | err_rvalid;
  assign bresp_o  = sram_bresp_i | uart_bresp_i | clint_bresp_i |
                    (err_bvalid ? RESP_DECERR : RESP_OKAY);
  assign bvalid_o = sram_bvalid_i | uart_bvalid_i | clint_bvalid_i | err_bvalid;

endmodule

//--- src/clint_slave.sv
`timescale 1ns/1ps

module clint_slave #(
  parameter bit DELAY_EN = 1'b1,
  parameter logic [bus_pkg::LFSR_W-1:0] LFSR_SEED = 20'h00065
) (
  input  logic clk,
  input  logic rst,
  input  logic [bus_pkg::ADDR_W-1:0] araddr_i,
  input  logic arvalid_i,
  output logic [bus_pkg::DATA_W-1:0] rdata_o,
  output bus_pkg::resp_t rresp_o,
  output logic rvalid_o,
  input  logic rready_i,
  input  logic [bus_pkg::ADDR_W-1:0] awaddr_i,
  input  logic awvalid_i,
  input  logic [bus_pkg::DATA_W-1:0] wdata_i,
  input  logic [bus_pkg::STRB_W-1:0] wstrb_i,
  input  logic wvalid_i,
  output bus_pkg::resp_t bresp_o,
  output logic bvalid_o,
  input  logic bready_i
);
  import bus_pkg::*;

  logic [63:0] mtime;
  logic gate_ok;
  logic rd_accept;
  logic wr_accept;

  bus_delay_gate #(
    .DELAY_EN (DELAY_EN),
    .LFSR_SEED(LFSR_SEED)
  ) i_delay_gate (
    .clk    (clk),
    .rst    (rst),
    .ready_o(gate_ok)
  );

  assign rd_accept = arvalid_i & ~rvalid_o & rready_i & gate_ok;
  assign wr_accept = awvalid_i & wvalid_i & ~bvalid_o & bready_i & gate_ok;

  always_ff @(posedge clk) begin
    if (rst) begin
      mtime    <= '0;
      rvalid_o <= 1'b0;
      bvalid_o <= 1'b0;
    end else begin
      mtime    <= mtime + 64'd1;
      rvalid_o <= rd_accept;
      bvalid_o <= wr_accept;  // Writes complete but leave the counter alone
    end
  end

  // The counter half is taken as it stood at the accepting edge
  always_ff @(posedge clk) begin
    rdata_o <= '0;
    if (rd_accept) begin
      case (araddr_i)
        RTC_ADDR_LO: rdata_o <= mtime[31:0];
        RTC_ADDR_HI: rdata_o <= mtime[63:32];
        default:     rdata_o <= '0;
      endcase
    end
  end

  assign rresp_o = RESP_OKAY;
  assign bresp_o = RESP_OKAY;

endmodule

//--- src/soc_bus_top.sv
`timescale 1ns/1ps

module soc_bus_top #(
  parameter bit DELAY_EN = 1'b1,
  parameter int unsigned SRAM_WORDS = 256
) (
  input  logic clk,
  input  logic rst,
  input  logic [bus_pkg::ADDR_W-1:0] araddr_i,
  input  logic arvalid_i,
  output logic [bus_pkg::DATA_W-1:0] rdata_o,
  output bus_pkg::resp_t rresp_o,
  output logic rvalid_o,
  input  logic rready_i,
  input  logic [bus_pkg::ADDR_W-1:0] awaddr_i,
  input  logic awvalid_i,
  input  logic [bus_pkg::DATA_W-1:0] wdata_i,
  input  logic [bus_pkg::STRB_W-1:0] wstrb_i,
  input  logic wvalid_i,
  output bus_pkg::resp_t bresp_o,
  output logic bvalid_o,
  input  logic bready_i,
  output logic [7:0] tx_byte_o,
  output logic tx_valid_o
);
  import bus_pkg::*;

  logic [ADDR_W-1:0] sram_araddr, sram_awaddr, uart_araddr, uart_awaddr;
  logic [ADDR_W-1:0] clint_araddr, clint_awaddr;
  logic [DATA_W-1:0] sram_rdata, sram_wdata, uart_rdata, uart_wdata;
  logic [DATA_W-1:0] clint_rdata, clint_wdata;
  logic [STRB_W-1:0] sram_wstrb, uart_wstrb, clint_wstrb;
  resp_t sram_rresp, sram_bresp, uart_rresp, uart_bresp, clint_rresp, clint_bresp;
  logic sram_arvalid, sram_rvalid, sram_rready, sram_awvalid, sram_wvalid;
  logic sram_bvalid, sram_bready;
  logic uart_arvalid, uart_rvalid, uart_rready, uart_awvalid, uart_wvalid;
  logic uart_bvalid, uart_bready;
  logic clint_arvalid, clint_rvalid, clint_rready, clint_awvalid, clint_wvalid;
  logic clint_bvalid, clint_bready;

  bus_xbar #(.SRAM_WORDS(SRAM_WORDS)) i_bus_xbar (
    .clk, .rst,
    .araddr_i, .arvalid_i, .rdata_o, .rresp_o, .rvalid_o, .rready_i,
    .awaddr_i, .awvalid_i, .wdata_i, .wstrb_i, .wvalid_i, .bresp_o, .bvalid_o, .bready_i,
    .sram_araddr_o(sram_araddr), .sram_arvalid_o(sram_arvalid), .sram_rdata_i(sram_rdata),
    .sram_rresp_i(sram_rresp), .sram_rvalid_i(sram_rvalid), .sram_rready_o(sram_rready),
    .sram_awaddr_o(sram_awaddr), .sram_awvalid_o(sram_awvalid), .sram_wdata_o(sram_wdata),
    .sram_wstrb_o(sram_wstrb), .sram_wvalid_o(sram_wvalid), .sram_bresp_i(sram_bresp),
    .sram_bvalid_i(sram_bvalid), .sram_bready_o(sram_bready),
    .uart_araddr_o(uart_araddr), .uart_arvalid_o(uart_arvalid), .uart_rdata_i(uart_rdata),
    .uart_rresp_i(uart_rresp), .uart_rvalid_i(uart_rvalid), .uart_rready_o(uart_rready),
    .uart_awaddr_o(uart_awaddr), .uart_awvalid_o(uart_awvalid), .uart_wdata_o(uart_wdata),
    .uart_wstrb_o(uart_wstrb), .uart_wvalid_o(uart_wvalid), .uart_bresp_i(uart_bresp),
    .uart_bvalid_i(uart_bvalid), .uart_bready_o(uart_bready),
    .clint_araddr_o(clint_araddr), .clint_arvalid_o(clint_arvalid),
    .clint_rdata_i(clint_rdata), .clint_rresp_i(clint_rresp),
    .clint_rvalid_i(clint_rvalid), .clint_rready_o(clint_rready),
    .clint_awaddr_o(clint_awaddr), .clint_awvalid_o(clint_awvalid),
    .clint_wdata_o(clint_wdata), .clint_wstrb_o(clint_wstrb), .clint_wvalid_o(clint_wvalid),
    .clint_bresp_i(clint_bresp), .clint_bvalid_i(clint_bvalid), .clint_bready_o(clint_bready)
  );

  sram_slave #(
    .SRAM_WORDS(SRAM_WORDS), .DELAY_EN(DELAY_EN), .LFSR_SEED(20'h00065)
  ) i_sram_slave (
    .clk, .rst,
    .araddr_i(sram_araddr), .arvalid_i(sram_arvalid), .rdata_o(sram_rdata),
    .rresp_o(sram_rresp), .rvalid_o(sram_rvalid), .rready_i(sram_rready),
    .awaddr_i(sram_awaddr), .awvalid_i(sram_awvalid), .wdata_i(sram_wdata),
    .wstrb_i(sram_wstrb), .wvalid_i(sram_wvalid), .bresp_o(sram_bresp),
    .bvalid_o(sram_bvalid), .bready_i(sram_bready)
  );

  uart_slave #(.DELAY_EN(DELAY_EN), .LFSR_SEED(20'h5a3c1)) i_uart_slave (
    .clk, .rst,
    .araddr_i(uart_araddr), .arvalid_i(uart_arvalid), .rdata_o(uart_rdata),
    .rresp_o(uart_rresp), .rvalid_o(uart_rvalid), .rready_i(uart_rready),
    .awaddr_i(uart_awaddr), .awvalid_i(uart_awvalid), .wdata_i(uart_wdata),
    .wstrb_i(uart_wstrb), .wvalid_i(uart_wvalid), .bresp_o(uart_bresp),
    .bvalid_o(uart_bvalid), .bready_i(uart_bready), .tx_byte_o, .tx_valid_o
  );

  clint_slave #(.DELAY_EN(DELAY_EN), .LFSR_SEED(20'h0b7e9)) i_clint_slave (
    .clk, .rst,
    .araddr_i(clint_araddr), .arvalid_i(clint_arvalid), .rdata_o(clint_rdata),
    .rresp_o(clint_rresp), .rvalid_o(clint_rvalid), .rready_i(clint_rready),
    .awaddr_i(clint_awaddr), .awvalid_i(clint_awvalid), .wdata_i(clint_wdata),
    .wstrb_i(clint_wstrb), .wvalid_i(clint_wvalid), .bresp_o(clint_bresp),
    .bvalid_o(clint_bvalid), .bready_i(clint_bready)
  );

endmodule

//--- src/sram_slave.sv
`timescale 1ns/1ps

module sram_slave #(
  parameter int unsigned SRAM_WORDS = 256,
  parameter bit DELAY_EN = 1'b1,
  parameter logic [bus_pkg::LFSR_W-1:0] LFSR_SEED = 20'h00065
) (
  input  logic clk,
  input  logic rst,
  input  logic [bus_pkg::ADDR_W-1:0] araddr_i,
  input  logic arvalid_i,
  output logic [bus_pkg::DATA_W-1:0] rdata_o,
  output bus_pkg::resp_t rresp_o,
  output logic rvalid_o,
  input  logic rready_i,
  input  logic [bus_pkg::ADDR_W-1:0] awaddr_i,
  input  logic awvalid_i,
  input  logic [bus_pkg::DATA_W-1:0] wdata_i,
  input  logic [bus_pkg::STRB_W-1:0] wstrb_i,
  input  logic wvalid_i,
  output bus_pkg::resp_t bresp_o,
  output logic bvalid_o,
  input  logic bready_i
);
  import bus_pkg::*;

  localparam int unsigned IDX_W = $clog2(SRAM_WORDS);

  logic [DATA_W-1:0] mem [SRAM_WORDS];
  logic [ADDR_W-1:0] rd_off;
  logic [ADDR_W-1:0] wr_off;
  logic [IDX_W-1:0]  rd_idx;
  logic [IDX_W-1:0]  wr_idx;
  logic gate_ok;
  logic rd_accept;
  logic wr_accept;

  bus_delay_gate #(
    .DELAY_EN (DELAY_EN),
    .LFSR_SEED(LFSR_SEED)
  ) i_delay_gate (
    .clk    (clk),
    .rst    (rst),
    .ready_o(gate_ok)
  );

  assign rd_off = araddr_i - SRAM_BASE;
  assign wr_off = awaddr_i - SRAM_BASE;
  assign rd_idx = rd_off[IDX_W+1:2];  // Word offset into the array
  assign wr_idx = wr_off[IDX_W+1:2];

  assign rd_accept = arvalid_i & ~rvalid_o & rready_i & gate_ok;
  assign wr_accept = awvalid_i & wvalid_i & ~bvalid_o & bready_i & gate_ok;

  always_ff @(posedge clk) begin
    if (rst) begin
      rvalid_o <= 1'b0;
      bvalid_o <= 1'b0;
    end else begin
      rvalid_o <= rd_accept;
      bvalid_o <= wr_accept;
    end
  end

  // Data returns to zero between pulses so the crossbar can OR the slaves
  always_ff @(posedge clk) begin
    rdata_o <= rd_accept ? mem[rd_idx] : '0;
  end

  always_ff @(posedge clk) begin
    if (wr_accept) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (wstrb_i[b]) begin
          mem[wr_idx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  assign rresp_o = RESP_OKAY;
  assign bresp_o = RESP_OKAY;

endmodule

//--- src/uart_slave.sv
`timescale 1ns/1ps

module uart_slave #(
  parameter bit DELAY_EN = 1'b1,
  parameter logic [bus_pkg::LFSR_W-1:0] LFSR_SEED = 20'h00065
) (
  input  logic clk,
  input  logic rst,
  input  logic [bus_pkg::ADDR_W-1:0] araddr_i,
  input  logic arvalid_i,
  output logic [bus_pkg::DATA_W-1:0] rdata_o,
  output bus_pkg::resp_t rresp_o,
  output logic rvalid_o,
  input  logic rready_i,
  input  logic [bus_pkg::ADDR_W-1:0] awaddr_i,
  input  logic awvalid_i,
  input  logic [bus_pkg::DATA_W-1:0] wdata_i,
  input  logic [bus_pkg::STRB_W-1:0] wstrb_i,
  input  logic wvalid_i,
  output bus_pkg::resp_t bresp_o,
  output logic bvalid_o,
  input  logic bready_i,
  output logic [7:0] tx_byte_o,
  output logic tx_valid_o
);
  import bus_pkg::*;

  logic gate_ok;
  logic rd_accept;
  logic wr_accept;

  bus_delay_gate #(
    .DELAY_EN (DELAY_EN),
    .LFSR_SEED(LFSR_SEED)
  ) i_delay_gate (
    .clk    (clk),
    .rst    (rst),
    .ready_o(gate_ok)
  );

  assign rd_accept = arvalid_i & ~rvalid_o & rready_i & gate_ok;
  assign wr_accept = awvalid_i & wvalid_i & ~bvalid_o & bready_i & gate_ok;

  always_ff @(posedge clk) begin
    if (rst) begin
      rvalid_o   <= 1'b0;
      bvalid_o   <= 1'b0;
      tx_valid_o <= 1'b0;
    end else begin
      rvalid_o   <= rd_accept;
      bvalid_o   <= wr_accept;
      tx_valid_o <= wr_accept;  // Same cycle as the write response
    end
  end

  // The whole slot is one transmit register, the strobes do not matter
  always_ff @(posedge clk) begin
    if (wr_accept) begin
      tx_byte_o <= wdata_i[7:0];
    end
  end

  assign rdata_o = '0;
  assign rresp_o = RESP_OKAY;
  assign bresp_o = RESP_OKAY;

endmodule
